//--- hw/wormhole_pkg.sv
// Wormhole router shared definitions: directions, header field layout, allocator states
package wormhole_pkg;

  // Port directions, P is the local node
  typedef enum logic [2:0]
  {
    dir_local = 3'd0,
    dir_west  = 3'd1,
    dir_east  = 3'd2,
    dir_north = 3'd3,
    dir_south = 3'd4
  } dir_e;

  localparam int num_dirs_c = 5;

  // Header field widths
  localparam int x_width_c   = 4;
  localparam int y_width_c   = 4;
  localparam int len_width_c = 4;

  // Field offsets counted down from the flit MSB
  // x sits on top, then y, then the body-flit count
  localparam int x_offset_c   = x_width_c;
  localparam int y_offset_c   = x_offset_c + y_width_c;
  localparam int len_offset_c = y_offset_c + len_width_c;

  // Per-output allocator state
  typedef enum logic
  {
    idle   = 1'b0,
    locked = 1'b1
  } alloc_state_e;

endpackage

//--- hw/input_buffer.sv
// Input buffer: two-entry flit FIFO, valid/ready toward the link and valid/yumi inside
`timescale 1ns/1ps

module input_buffer #(
  parameter int flit_width_p = 32
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    valid_i,
  input  logic [flit_width_p-1:0] data_i,
  output logic                    ready_o,
  output logic                    valid_o,
  output logic [flit_width_p-1:0] data_o,
  input  logic                    yumi_i
);

  logic [flit_width_p-1:0] head_r;
  logic [flit_width_p-1:0] tail_r;
  logic head_v_r;
  logic tail_v_r;
  logic head_v_n;
  logic tail_v_n;
  logic push;
  logic load_head_in;
  logic load_head_tail;
  logic load_tail;

  // The tail only fills behind a valid head, so a valid tail means full
  assign ready_o = ~tail_v_r;
  assign push    = valid_i & ready_o;
  assign valid_o = head_v_r;
  assign data_o  = head_r;

  always_comb
  begin
    head_v_n       = head_v_r;
    tail_v_n       = tail_v_r;
    load_head_in   = 1'b0;
    load_head_tail = 1'b0;
    load_tail      = 1'b0;
    if (yumi_i)
    begin
      if (tail_v_r)
      begin
        // Full, so no push can happen this cycle
        load_head_tail = 1'b1;
        tail_v_n       = 1'b0;
      end
      else
      begin
        head_v_n     = push;
        load_head_in = push;
      end
    end
    else if (push)
    begin
      if (head_v_r)
      begin
        tail_v_n  = 1'b1;
        load_tail = 1'b1;
      end
      else
      begin
        head_v_n     = 1'b1;
        load_head_in = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      head_v_r <= 1'b0;
      tail_v_r <= 1'b0;
    end
    else
    begin
      head_v_r <= head_v_n;
      tail_v_r <= tail_v_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (load_head_in)
      head_r <= data_i;
    else if (load_head_tail)
      head_r <= tail_r;
    if (load_tail)
      tail_r <= data_i;
  end

endmodule

//--- hw/route_compute.sv
// Route compute: XY route decision on header flits, held for the body of the packet
`timescale 1ns/1ps

module route_compute
  import wormhole_pkg::*;
#(
  parameter int flit_width_p = 32
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    head_valid_i,
  input  logic [flit_width_p-1:0] head_data_i,
  input  logic                    pop_i,
  input  logic [x_width_c-1:0]    my_x_i,
  input  logic [y_width_c-1:0]    my_y_i,
  output logic [num_dirs_c-1:0]   route_req_o
);

  logic [len_width_c-1:0] count_r;
  logic [num_dirs_c-1:0]  route_r;
  logic [num_dirs_c-1:0]  hdr_route;
  logic [x_width_c-1:0]   dst_x;
  logic [y_width_c-1:0]   dst_y;
  logic [len_width_c-1:0] hdr_len;
  logic                   at_header;
  dir_e                   route_dir;

  assign dst_x   = head_data_i[flit_width_p-x_offset_c +: x_width_c];
  assign dst_y   = head_data_i[flit_width_p-y_offset_c +: y_width_c];
  assign hdr_len = head_data_i[flit_width_p-len_offset_c +: len_width_c];

  // A zero body count means the head flit is a header
  assign at_header = (count_r == '0);

  // West and north have the smaller coordinates
  always_comb
  begin
    if (dst_x < my_x_i)
      route_dir = dir_west;
    else if (dst_x > my_x_i)
      route_dir = dir_east;
    else if (dst_y < my_y_i)
      route_dir = dir_north;
    else if (dst_y > my_y_i)
      route_dir = dir_south;
    else
      route_dir = dir_local;
    hdr_route            = '0;
    hdr_route[route_dir] = 1'b1;
  end

  always_comb
  begin
    if (!head_valid_i)
      route_req_o = '0;
    else if (at_header)
      route_req_o = hdr_route;
    else
      route_req_o = route_r;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      count_r <= '0;
      route_r <= '0;
    end
    else if (pop_i)
    begin
      if (at_header)
      begin
        count_r <= hdr_len;
        route_r <= hdr_route;
      end
      else
        count_r <= count_r - 1'b1;
    end
  end

endmodule

//--- hw/switch_allocator.sv
// Switch allocator: per-output round robin with packet-long grant locks and FIFO pops
`timescale 1ns/1ps

module switch_allocator
  import wormhole_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic [num_dirs_c-1:0][num_dirs_c-1:0]   req_i,
  input  logic [num_dirs_c-1:0]                   head_valid_i,
  input  logic [num_dirs_c-1:0]                   out_ready_i,
  input  logic [num_dirs_c-1:0][len_width_c-1:0]  head_len_i,
  output logic [num_dirs_c-1:0][num_dirs_c-1:0]   grant_o,
  output logic [num_dirs_c-1:0]                   out_valid_o,
  output logic [num_dirs_c-1:0]                   yumi_o
);

  logic [num_dirs_c-1:0] xfer;

  for (genvar o = 0; o < num_dirs_c; o++)
  begin : g_out
    logic [num_dirs_c-1:0]  col_req;
    logic [num_dirs_c-1:0]  arb_req;
    logic [num_dirs_c-1:0]  arb_grant;
    logic [num_dirs_c-1:0]  grant_r;
    logic [2:0]             ptr_r;
    logic [2:0]             win_idx;
    logic [len_width_c-1:0] win_len;
    logic [len_width_c-1:0] count_r;
    logic                   hold_r;
    alloc_state_e           state_r;

    // Only the local output takes traffic from its own input
    for (genvar i = 0; i < num_dirs_c; i++)
    begin : g_req
      assign col_req[i] = req_i[i][o] & head_valid_i[i]
                        & ((o == int'(dir_local)) || (i != o));
    end

    // A header stalled by the link keeps its grant until it leaves
    assign arb_req = hold_r ? (col_req & grant_r) : col_req;

    // Scan from the pointer upward; the closest requester is written last and wins
    always_comb
    begin : rr_scan
      int idx;
      arb_grant = '0;
      win_idx   = ptr_r;
      for (int k = num_dirs_c - 1; k >= 0; k--)
      begin
        idx = int'(ptr_r) + k;
        if (idx >= num_dirs_c)
          idx = idx - num_dirs_c;
        if (arb_req[idx])
        begin
          arb_grant      = '0;
          arb_grant[idx] = 1'b1;
          win_idx        = 3'(idx);
        end
      end
    end

    always_comb
    begin
      win_len = '0;
      for (int i = 0; i < num_dirs_c; i++)
        win_len = win_len | ({len_width_c{arb_grant[i]}} & head_len_i[i]);
    end

    assign grant_o[o]     = (state_r == locked) ? grant_r : arb_grant;
    assign out_valid_o[o] = |(grant_o[o] & col_req);
    assign xfer[o]        = out_valid_o[o] & out_ready_i[o];

    always_ff @(posedge clk_i)
    begin
      if (reset_i)
      begin
        state_r <= idle;
        count_r <= '0;
        grant_r <= '0;
        ptr_r   <= '0;
        hold_r  <= 1'b0;
      end
      else if (xfer[o])
      begin
        hold_r <= 1'b0;
        if (state_r == idle)
        begin
          // Header leaves, so priority moves past the winner
          ptr_r <= (win_idx == 3'(num_dirs_c - 1)) ? 3'd0 : win_idx + 3'd1;
          if (win_len != '0)
          begin
            state_r <= locked;
            count_r <= win_len;
            grant_r <= arb_grant;
          end
        end
        else
        begin
          count_r <= count_r - 1'b1;
          if (count_r == len_width_c'(1))
            state_r <= idle;
        end
      end
      else if ((state_r == idle) && out_valid_o[o])
      begin
        hold_r  <= 1'b1;
        grant_r <= arb_grant;
      end
    end
  end

  // Each input requests one output at a time, so at most one term is set
  always_comb
  begin
    yumi_o = '0;
    for (int o = 0; o < num_dirs_c; o++)
      for (int i = 0; i < num_dirs_c; i++)
        yumi_o[i] = yumi_o[i] | (xfer[o] & grant_o[o][i]);
  end

endmodule

//--- hw/crossbar.sv
// Crossbar: one-hot AND-OR flit multiplexers from five inputs to five outputs
`timescale 1ns/1ps

module crossbar
  import wormhole_pkg::*;
#(
  parameter int flit_width_p = 32
) (
  input  logic [num_dirs_c-1:0][flit_width_p-1:0] in_data_i,
  input  logic [num_dirs_c-1:0][num_dirs_c-1:0]   grant_i,
  output logic [num_dirs_c-1:0][flit_width_p-1:0] out_data_o
);

  always_comb
  begin
    for (int o = 0; o < num_dirs_c; o++)
    begin
      out_data_o[o] = '0;
      for (int i = 0; i < num_dirs_c; i++)
      begin
        // No U-turn path except on the local port
        if ((i != o) || (o == int'(dir_local)))
          out_data_o[o] = out_data_o[o]
                        | ({flit_width_p{grant_i[o][i]}} & in_data_i[i]);
      end
    end
  end

endmodule

//--- hw/wormhole_router_top.sv
// Wormhole router top: five-port mesh node with input FIFOs, XY routing and round-robin switch
`timescale 1ns/1ps

module wormhole_router_top
  import wormhole_pkg::*;
#(
  parameter int flit_width_p = 32
) (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic [x_width_c-1:0]                    my_x_i,
  input  logic [y_width_c-1:0]                    my_y_i,
  input  logic [num_dirs_c-1:0]                   link_valid_i,
  input  logic [num_dirs_c-1:0][flit_width_p-1:0] link_data_i,
  output logic [num_dirs_c-1:0]                   link_ready_o,
  output logic [num_dirs_c-1:0]                   link_valid_o,
  output logic [num_dirs_c-1:0][flit_width_p-1:0] link_data_o,
  input  logic [num_dirs_c-1:0]                   link_ready_i
);

  logic [num_dirs_c-1:0]                   fifo_valid;
  logic [num_dirs_c-1:0][flit_width_p-1:0] fifo_data;
  logic [num_dirs_c-1:0]                   fifo_yumi;
  logic [num_dirs_c-1:0][num_dirs_c-1:0]   route_req;
  logic [num_dirs_c-1:0][num_dirs_c-1:0]   grant;
  logic [num_dirs_c-1:0][len_width_c-1:0]  head_len;

  for (genvar d = 0; d < num_dirs_c; d++)
  begin : g_port
    input_buffer #(
      .flit_width_p(flit_width_p)
    ) i_buf (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .valid_i(link_valid_i[d]),
      .data_i (link_data_i[d]),
      .ready_o(link_ready_o[d]),
      .valid_o(fifo_valid[d]),
      .data_o (fifo_data[d]),
      .yumi_i (fifo_yumi[d])
    );

    route_compute #(
      .flit_width_p(flit_width_p)
    ) i_route (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .head_valid_i(fifo_valid[d]),
      .head_data_i (fifo_data[d]),
      .pop_i       (fifo_yumi[d]),
      .my_x_i      (my_x_i),
      .my_y_i      (my_y_i),
      .route_req_o (route_req[d])
    );

    // Length field of the head flit, meaningful to the allocator on headers
    assign head_len[d] = fifo_data[d][flit_width_p-len_offset_c +: len_width_c];
  end

  switch_allocator i_alloc (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (route_req),
    .head_valid_i(fifo_valid),
    .out_ready_i (link_ready_i),
    .head_len_i  (head_len),
    .grant_o     (grant),
    .out_valid_o (link_valid_o),
    .yumi_o      (fifo_yumi)
  );

  crossbar #(
    .flit_width_p(flit_width_p)
  ) i_xbar (
    .in_data_i (fifo_data),
    .grant_i   (grant),
    .out_data_o(link_data_o)
  );

endmodule

//--- tb/router_ref.svh
// Router reference model: XY route, Galois LFSR step and flit builder for the testbench
`ifndef ROUTER_REF_SVH
`define ROUTER_REF_SVH

// Payload fields sit right below the header
localparam int src_lsb_c = flit_width_c - len_offset_c - 3;
localparam int seq_lsb_c = src_lsb_c - 8;
localparam int idx_lsb_c = seq_lsb_c - 4;

// Dimension-ordered routing, x first
function automatic dir_e ref_route(input logic [x_width_c-1:0] dst_x,
                                   input logic [y_width_c-1:0] dst_y);
  if (dst_x < my_x_c)
    return dir_west;
  if (dst_x > my_x_c)
    return dir_east;
  if (dst_y < my_y_c)
    return dir_north;
  if (dst_y > my_y_c)
    return dir_south;
  return dir_local;
endfunction

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  if (s[0])
    return (s >> 1) ^ 32'h80200003;
  return s >> 1;
endfunction

// Every flit carries the header fields, so body flits also name their output
function automatic logic [flit_width_c-1:0] make_flit(input logic [x_width_c-1:0] x,
                                                      input logic [y_width_c-1:0] y,
                                                      input logic [len_width_c-1:0] len,
                                                      input logic [2:0] src,
                                                      input logic [7:0] seq,
                                                      input logic [3:0] idx);
  logic [flit_width_c-1:0] f;
  f = '0;
  f[flit_width_c-x_offset_c +: x_width_c]     = x;
  f[flit_width_c-y_offset_c +: y_width_c]     = y;
  f[flit_width_c-len_offset_c +: len_width_c] = len;
  f[src_lsb_c +: 3] = src;
  f[seq_lsb_c +: 8] = seq;
  f[idx_lsb_c +: 4] = idx;
  return f;
endfunction

`endif

//--- tb/wormhole_router_tb.sv
// Wormhole router testbench: random XY traffic on five ports with per-source scoreboards
`timescale 1ns/1ps

module wormhole_router_tb
  import wormhole_pkg::*;
();

  localparam int flit_width_c = 32;
  localparam int my_x_c       = 5;
  localparam int my_y_c       = 5;
  localparam int packets_c    = 40;
  localparam int timeout_c    = packets_c * 4 * num_dirs_c * 4;

  logic                                    clk_i;
  logic                                    reset_i;
  logic [x_width_c-1:0]                    my_x_i;
  logic [y_width_c-1:0]                    my_y_i;
  logic [num_dirs_c-1:0]                   link_valid_i;
  logic [num_dirs_c-1:0][flit_width_c-1:0] link_data_i;
  logic [num_dirs_c-1:0]                   link_ready_o;
  logic [num_dirs_c-1:0]                   link_valid_o;
  logic [num_dirs_c-1:0][flit_width_c-1:0] link_data_o;
  logic [num_dirs_c-1:0]                   link_ready_i;

  logic [31:0]                             lfsr_state;
  logic [flit_width_c-1:0]                 send_q [num_dirs_c][$];
  // Expected flits, indexed by source * 5 + output
  logic [flit_width_c-1:0]                 exp_q [num_dirs_c*num_dirs_c][$];
  logic [num_dirs_c-1:0]                   held;
  logic [num_dirs_c-1:0]                   in_xfer;
  logic [num_dirs_c-1:0][flit_width_c-1:0] held_data;
  logic [num_dirs_c-1:0][len_width_c-1:0]  remaining;
  dir_e                                    owner [num_dirs_c];
  int                                      dir_errs;
  int                                      flit_errs;
  int                                      other_errs;

  `include "router_ref.svh"

  wormhole_router_top #(
    .flit_width_p(flit_width_c)
  ) i_dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .my_x_i      (my_x_i),
    .my_y_i      (my_y_i),
    .link_valid_i(link_valid_i),
    .link_data_i (link_data_i),
    .link_ready_o(link_ready_o),
    .link_valid_o(link_valid_o),
    .link_data_o (link_data_o),
    .link_ready_i(link_ready_i)
  );

  always #4 clk_i = ~clk_i;

  function automatic logic rand_bit();
    logic b;
    b          = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
    return b;
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[6:0], rand_bit()};
    return v;
  endfunction

  task automatic check_dir(input string name, input dir_e exp, input dir_e act);
    if (exp != act)
    begin
      $display("error %s: expected %0d, actual %0d", name, exp, act);
      dir_errs++;
    end
  endtask

  task automatic check_flit(input string name, input logic [flit_width_c-1:0] exp,
                            input logic [flit_width_c-1:0] act);
    if (exp !== act)
    begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      flit_errs++;
    end
  endtask

  // Coordinates around the node; the last ten packets of each input all go local
  task automatic build_traffic();
    logic [x_width_c-1:0]   x;
    logic [y_width_c-1:0]   y;
    logic [len_width_c-1:0] len;
    for (int d = 0; d < num_dirs_c; d++)
      for (int p = 0; p < packets_c; p++)
      begin
        do
        begin
          x = x_width_c'(4 + rand_bits(2));
          y = y_width_c'(4 + rand_bits(2));
          if (p >= packets_c - 10)
          begin
            x = x_width_c'(my_x_c);
            y = y_width_c'(my_y_c);
          end
        end while ((d != int'(dir_local)) && (ref_route(x, y) == dir_e'(d)));
        len = len_width_c'(rand_bits(2));
        for (int f = 0; f <= int'(len); f++)
          send_q[d].push_back(make_flit(x, y, len, 3'(d), 8'(p), 4'(f)));
      end
  endtask

  task automatic take_flit(input int o, input logic [flit_width_c-1:0] flit);
    int                      src;
    int                      key;
    logic [flit_width_c-1:0] exp;
    src = int'(flit[src_lsb_c +: 3]);
    if (src >= num_dirs_c)
    begin
      $display("flit %h on output %0d carries an unknown source", flit, o);
      other_errs++;
      return;
    end
    key = src * num_dirs_c + o;
    if (exp_q[key].size() == 0)
    begin
      $display("flit %h from source %0d on output %0d was never sent there", flit, src, o);
      other_errs++;
    end
    else
    begin
      exp = exp_q[key].pop_front();
      check_flit("data", exp, flit);
    end
    // Header when the output holds no open packet
    if (remaining[o] == '0)
    begin
      check_dir("route", ref_route(flit[flit_width_c-x_offset_c +: x_width_c],
                                   flit[flit_width_c-y_offset_c +: y_width_c]), dir_e'(o));
      remaining[o] = flit[flit_width_c-len_offset_c +: len_width_c];
      owner[o]     = dir_e'(src);
    end
    else
    begin
      check_dir("packet", owner[o], dir_e'(src));
      remaining[o] = remaining[o] - 1'b1;
    end
  endtask

  // Looks at the output transfers that the next rising edge makes
  task automatic check_outputs();
    for (int o = 0; o < num_dirs_c; o++)
    begin
      if (held[o])
      begin
        if (!link_valid_o[o])
        begin
          $display("output %0d dropped valid before its flit was taken", o);
          other_errs++;
        end
        else
          check_flit("hold", held_data[o], link_data_o[o]);
      end
      held[o]      = link_valid_o[o] & ~link_ready_i[o];
      held_data[o] = link_data_o[o];
      if (link_valid_o[o] && link_ready_i[o])
        take_flit(o, link_data_o[o]);
    end
  endtask

  // Ready is register-driven, so its value now is the one the next edge sees
  task automatic drive_inputs();
    logic [flit_width_c-1:0] flit;
    for (int d = 0; d < num_dirs_c; d++)
    begin
      if (in_xfer[d])
      begin
        link_valid_i[d] = 1'b0;
        in_xfer[d]      = 1'b0;
      end
      if (!link_valid_i[d] && (send_q[d].size() > 0) && rand_bit())
      begin
        link_valid_i[d] = 1'b1;
        link_data_i[d]  = send_q[d].pop_front();
      end
      if (link_valid_i[d] && link_ready_o[d])
      begin
        flit = link_data_i[d];
        exp_q[d * num_dirs_c + int'(ref_route(flit[flit_width_c-x_offset_c +: x_width_c],
              flit[flit_width_c-y_offset_c +: y_width_c]))].push_back(flit);
        in_xfer[d] = 1'b1;
      end
      link_ready_i[d] = rand_bit();
    end
  endtask

  function automatic logic all_delivered();
    for (int d = 0; d < num_dirs_c; d++)
      if ((send_q[d].size() != 0) || link_valid_i[d])
        return 1'b0;
    for (int k = 0; k < num_dirs_c * num_dirs_c; k++)
      if (exp_q[k].size() != 0)
        return 1'b0;
    return 1'b1;
  endfunction

  initial
  begin
    int   cycles;
    logic done;
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    my_x_i       = x_width_c'(my_x_c);
    my_y_i       = y_width_c'(my_y_c);
    link_valid_i = '0;
    link_data_i  = '0;
    link_ready_i = '0;
    lfsr_state   = 32'd77060;
    held         = '0;
    held_data    = '0;
    in_xfer      = '0;
    remaining    = '0;
    dir_errs     = 0;
    flit_errs    = 0;
    other_errs   = 0;
    cycles       = 0;
    done         = 1'b0;
    for (int o = 0; o < num_dirs_c; o++)
      owner[o] = dir_local;
    build_traffic();
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    for (int o = 0; o < num_dirs_c; o++)
      if (link_valid_o[o] || !link_ready_o[o])
      begin
        $display("port %0d is not idle and ready after reset", o);
        other_errs++;
      end
    while (!done && (cycles < timeout_c))
    begin
      @(negedge clk_i);
      cycles++;
      drive_inputs();
      check_outputs();
      done = all_delivered();
    end
    if (!done)
    begin
      $display("timeout: not all flits delivered");
      other_errs++;
    end
    $display("errors: route/packet %0d, data %0d, other %0d", dir_errs, flit_errs, other_errs);
    if (dir_errs + flit_errs + other_errs == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

//--- wormhole_router_top.f
+incdir+tb
hw/wormhole_pkg.sv
hw/input_buffer.sv
hw/route_compute.sv
hw/switch_allocator.sv
hw/crossbar.sv
hw/wormhole_router_top.sv
tb/wormhole_router_tb.sv

//--- run_sim.sh
#!/bin/bash
# Build the router testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary -Wno-fatal --top-module wormhole_router_tb -f wormhole_router_top.f \
  && ./obj_dir/Vwormhole_router_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
